// ==== project.f ====
common/routerPkg.sv
inputPort/inputPort.sv
arbiter/grantTimer.sv
arbiter/outputArbiter.sv
source/switchFabric.sv
source/meshRouter.sv
test/switchFabric_checker.sv
test/meshRouterTb.sv

// ==== test/meshRouterTb.sv ====
`timescale 1ns/1ps

module meshRouterTb;
  import routerPkg::*;

  localparam int ROUTER_X = 1;
  localparam int ROUTER_Y = 1;
  localparam int FIFO_DEPTH = 16;
  localparam int PKTS_RANDOM = 12;   // per input
  localparam int PKTS_FLOOD = 6;     // per flooding input
  localparam int TOTAL_PKTS = NUM_PORTS * PKTS_RANDOM + 4 * PKTS_FLOOD;
  localparam int WATCHDOG_NS = TOTAL_PKTS * 8 * NUM_PORTS * 40 + 20000;

  logic clk = 1'b0;
  logic rst;
  logic inValid [NUM_PORTS];
  flitT inFlit [NUM_PORTS];
  logic outValid [NUM_PORTS];
  flitT outFlit [NUM_PORTS];

  logic [31:0] rngState = 32'hb7d7_1d73;
  flitT expQ [NUM_PORTS][NUM_PORTS][$];   // by source, then output
  flitT txQ [NUM_PORTS][$];
  int pktLeft [NUM_PORTS];
  int gap [NUM_PORTS];
  int serial [NUM_PORTS];
  int sent [NUM_PORTS];
  int recvd [NUM_PORTS];
  int rxState [NUM_PORTS];   // 0 idle, 1 header seen, 2 inside packet
  int rxSrc [NUM_PORTS];
  flitT rxHead [NUM_PORTS];
  bit floodMode;
  bit idlePhase;
  int mismatchErrors;
  int otherErrors;

  meshRouter #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .clk(clk), .rst(rst),
    .inValidL(inValid[0]), .inValidN(inValid[1]), .inValidE(inValid[2]),
    .inValidW(inValid[3]), .inValidS(inValid[4]),
    .inFlitL(inFlit[0]), .inFlitN(inFlit[1]), .inFlitE(inFlit[2]),
    .inFlitW(inFlit[3]), .inFlitS(inFlit[4]),
    .outValidL(outValid[0]), .outValidN(outValid[1]), .outValidE(outValid[2]),
    .outValidW(outValid[3]), .outValidS(outValid[4]),
    .outFlitL(outFlit[0]), .outFlitN(outFlit[1]), .outFlitE(outFlit[2]),
    .outFlitW(outFlit[3]), .outFlitS(outFlit[4])
  );

  always #20 clk = ~clk;

  function logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // x first, then y
  function int routeOf(int dx, int dy);
    if (dx > ROUTER_X)
      return PORT_E;
    if (dx < ROUTER_X)
      return PORT_W;
    if (dy < ROUTER_Y)
      return PORT_N;
    if (dy > ROUTER_Y)
      return PORT_S;
    return PORT_L;
  endfunction

  task automatic buildPacket(int p);
    int len;
    int dx;
    int dy;
    int out;
    flitT f;
    len = 2 + nextRand() % 7;
    dx = floodMode ? ROUTER_X : nextRand() % 4;
    dy = floodMode ? ROUTER_Y : nextRand() % 4;
    out = routeOf(dx, dy);
    for (int i = 0; i < len; i++)
    begin
      f.flitId = (i == 0) ? FLIT_HEAD : (i == len - 1) ? FLIT_TAIL : FLIT_BODY;
      if (i == 0)
        f.data = {dx[1:0], dy[1:0], 12'(len)};
      else
        f.data = {p[2:0], serial[p][8:0], i[3:0]};   // source, serial, index
      txQ[p].push_back(f);
      expQ[p][out].push_back(f);
    end
    serial[p]++;
  endtask

  task automatic driveInputs();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inValid[p] = 1'b0;
      if (txQ[p].size() == 0 && gap[p] > 0)
        gap[p]--;
      else if (txQ[p].size() == 0 && pktLeft[p] > 0 && sent[p] - recvd[p] <= FIFO_DEPTH - 10)
      begin
        buildPacket(p);
        pktLeft[p]--;
        gap[p] = nextRand() % 4;
      end
      if (txQ[p].size() != 0)
      begin
        inValid[p] = 1'b1;
        inFlit[p] = txQ[p].pop_front();
        sent[p]++;
      end
    end
  endtask

  task automatic compareFlit(string testName, flitT expected, flitT actual);
    assert (actual === expected)
    else
    begin
      mismatchErrors++;
      $display("MISMATCH %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic takeFlit(int o, flitT f);
    int src;
    flitT expected;
    if (rxState[o] == 0)
    begin
      assert (f.flitId == FLIT_HEAD)
      else
      begin
        otherErrors++;
        $display("output %0d sent a flit that does not follow a header", o);
      end
      rxHead[o] = f;
      rxState[o] = (f.flitId == FLIT_HEAD) ? 1 : 0;
      return;
    end
    if (rxState[o] == 1)
    begin
      src = f.data[15:13];   // tag names the source
      assert (src < NUM_PORTS && expQ[src][o].size() >= 2)
      else
      begin
        otherErrors++;
        $display("output %0d sent a packet that no input should route there", o);
      end
      if (src >= NUM_PORTS || expQ[src][o].size() < 2)
      begin
        rxState[o] = 0;
        return;
      end
      compareFlit("routing", expQ[src][o].pop_front(), rxHead[o]);
      recvd[src]++;
      rxSrc[o] = src;
      rxState[o] = 2;
    end
    src = rxSrc[o];
    expected = expQ[src][o].pop_front();
    compareFlit("integrity", expected, f);
    recvd[src]++;
    if (expected.flitId == FLIT_TAIL)
      rxState[o] = 0;
  endtask

  function automatic int pendingFlits();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      n += txQ[p].size() + pktLeft[p];
      for (int o = 0; o < NUM_PORTS; o++)
        n += expQ[p][o].size();
    end
    return n;
  endfunction

  task automatic runPhase(bit flood);
    floodMode = flood;
    for (int p = 0; p < NUM_PORTS; p++)
      pktLeft[p] = !flood ? PKTS_RANDOM : (p == PORT_L) ? 0 : PKTS_FLOOD;
    while (pendingFlits() != 0)
    begin
      @(posedge clk);
      #2;
      driveInputs();
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      for (int o = 0; o < NUM_PORTS; o++)
        if (outValid[o])
        begin
          assert (!idlePhase)
          else
          begin
            otherErrors++;
            $display("output %0d went valid with no input activity", o);
          end
          takeFlit(o, outFlit[o]);
        end
  end

  initial
  begin
    rst = 1'b1;
    idlePhase = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inValid[p] = 1'b0;
      inFlit[p] = '0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (10) @(posedge clk);   // outputs must stay quiet
    #2;
    idlePhase = 1'b0;
    runPhase(1'b0);
    runPhase(1'b1);   // N, E, W, S all onto Local
    repeat (20) @(posedge clk);   // room for stray flits
    for (int o = 0; o < NUM_PORTS; o++)
      assert (rxState[o] == 0)
      else
      begin
        otherErrors++;
        $display("output %0d stopped in the middle of a packet", o);
      end
    otherErrors += dut0.fabric0.fabricCheck0.failCount;   // bound assertion failures
    $display("error counts: %0d mismatches, %0d other", mismatchErrors, otherErrors);
    if (mismatchErrors + otherErrors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    otherErrors++;
    $display("watchdog timeout, traffic did not drain within %0d ns", WATCHDOG_NS);
    otherErrors += dut0.fabric0.fabricCheck0.failCount;
    $display("error counts: %0d mismatches, %0d other", mismatchErrors, otherErrors);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== test/switchFabric_checker.sv ====
`timescale 1ns/1ps

module switchFabricChecker (
  input logic                                          clk,
  input logic                                          rst,
  input routerPkg::portVecT [routerPkg::NUM_PORTS-1:0] grant,
  input routerPkg::portVecT [routerPkg::NUM_PORTS-1:0] reqToOut,
  input routerPkg::portVecT [routerPkg::NUM_PORTS-1:0] sendMask,
  input routerPkg::flitT    [routerPkg::NUM_PORTS-1:0] headFlit,
  input routerPkg::portVecT [routerPkg::NUM_PORTS-1:0] timesUp
);
  import routerPkg::*;

  int failCount = 0;

  for (genvar o = 0; o < NUM_PORTS; o++)
  begin : outChk
    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant[o]))
      else
      begin
        failCount++;
        $error("output %0d grant is not one-hot", o);
      end
    for (genvar k = 0; k < NUM_PORTS; k++)
    begin : inChk
      // a held grant only moves once the timer runs out on the tail
      holdUntilTimeout: assert property (@(posedge clk) disable iff (rst)
        grant[o][k] && reqToOut[o][k]
          && !(timesUp[o][k] && headFlit[k].flitId == FLIT_TAIL) |=> grant[o][k])
        else
        begin
          failCount++;
          $error("output %0d dropped input %0d before its tail left", o, k);
        end
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : popChk
    singlePop: assert property (@(posedge clk) disable iff (rst)
      $onehot0({sendMask[4][i], sendMask[3][i], sendMask[2][i], sendMask[1][i], sendMask[0][i]}))
      else
      begin
        failCount++;
        $error("input %0d popped by more than one output", i);
      end
  end

endmodule

bind switchFabric switchFabricChecker fabricCheck0 (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .reqToOut (reqToOut),
  .sendMask (sendMask),
  .headFlit (headFlit),
  .timesUp  ({outGen[4].arb0.timesUp, outGen[3].arb0.timesUp, outGen[2].arb0.timesUp,
              outGen[1].arb0.timesUp, outGen[0].arb0.timesUp})
);

// ==== source/meshRouter.sv ====
`timescale 1ns/1ps

module meshRouter #(
  parameter int ROUTER_X = 1,
  parameter int ROUTER_Y = 1,
  parameter int FIFO_DEPTH = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValidL,
  input  logic            inValidN,
  input  logic            inValidE,
  input  logic            inValidW,
  input  logic            inValidS,
  input  routerPkg::flitT inFlitL,
  input  routerPkg::flitT inFlitN,
  input  routerPkg::flitT inFlitE,
  input  routerPkg::flitT inFlitW,
  input  routerPkg::flitT inFlitS,
  output logic            outValidL,
  output logic            outValidN,
  output logic            outValidE,
  output logic            outValidW,
  output logic            outValidS,
  output routerPkg::flitT outFlitL,
  output routerPkg::flitT outFlitN,
  output routerPkg::flitT outFlitE,
  output routerPkg::flitT outFlitW,
  output routerPkg::flitT outFlitS
);
  import routerPkg::*;

  portVecT                 inValid;
  flitT [NUM_PORTS-1:0]    inFlit;
  portVecT [NUM_PORTS-1:0] req;
  flitT [NUM_PORTS-1:0]    headFlit;
  portVecT                 pop;
  portVecT                 outValid;
  flitT [NUM_PORTS-1:0]    outFlit;

  // packed in port index order, L at bit 0
  assign inValid = {inValidS, inValidW, inValidE, inValidN, inValidL};
  assign inFlit = {inFlitS, inFlitW, inFlitE, inFlitN, inFlitL};

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : inGen
    inputPort #(
      .ROUTER_X   (ROUTER_X),
      .ROUTER_Y   (ROUTER_Y),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) port0 (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inFlit   (inFlit[p]),
      .pop      (pop[p]),
      .req      (req[p]),
      .headFlit (headFlit[p])
    );
  end

  switchFabric fabric0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .pop      (pop),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  assign outValidL = outValid[PORT_L];
  assign outValidN = outValid[PORT_N];
  assign outValidE = outValid[PORT_E];
  assign outValidW = outValid[PORT_W];
  assign outValidS = outValid[PORT_S];
  assign outFlitL = outFlit[PORT_L];
  assign outFlitN = outFlit[PORT_N];
  assign outFlitE = outFlit[PORT_E];
  assign outFlitW = outFlit[PORT_W];
  assign outFlitS = outFlit[PORT_S];

endmodule

// ==== source/switchFabric.sv ====
`timescale 1ns/1ps

module switchFabric (
  input  logic                                       clk,
  input  logic                                       rst,
  input  routerPkg::portVecT [routerPkg::NUM_PORTS-1:0] req,
  input  routerPkg::flitT    [routerPkg::NUM_PORTS-1:0] headFlit,
  output routerPkg::portVecT                         pop,
  output routerPkg::portVecT                         outValid,
  output routerPkg::flitT    [routerPkg::NUM_PORTS-1:0] outFlit
);
  import routerPkg::*;

  portVecT [NUM_PORTS-1:0] reqToOut;   // indexed by output, bit per input
  portVecT [NUM_PORTS-1:0] grant;
  portVecT [NUM_PORTS-1:0] sendMask;
  portVecT                 headIsHeader;
  logic [NUM_PORTS-1:0][LEN_WIDTH-1:0] headLen;
  flitT [NUM_PORTS-1:0]    selFlit;

  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      headIsHeader[i] = headFlit[i].flitId == FLIT_HEAD;
      headLen[i] = headLength(headFlit[i]);
      for (int o = 0; o < NUM_PORTS; o++)
        reqToOut[o][i] = req[i][o];
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++)
  begin : outGen
    outputArbiter arb0 (
      .clk          (clk),
      .rst          (rst),
      .reqIn        (reqToOut[o]),
      .popIn        (pop),
      .headIsHeader (headIsHeader),
      .headLength   (headLen),
      .grant        (grant[o])
    );
  end

  always_comb
  begin
    pop = '0;
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      sendMask[o] = grant[o] & reqToOut[o];
      pop = pop | sendMask[o];
    end
  end

  // crossbar mux, grant is one-hot
  always_comb
  begin
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      selFlit[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++)
        if (grant[o][i])
          selFlit[o] = headFlit[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= '0;
    else
      for (int o = 0; o < NUM_PORTS; o++)
        outValid[o] <= |sendMask[o];
  end

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < NUM_PORTS; o++)
      if (|sendMask[o])
        outFlit[o] <= selFlit[o];
  end

endmodule

// ==== arbiter/outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  routerPkg::portVecT                                   reqIn,
  input  routerPkg::portVecT                                   popIn,
  input  routerPkg::portVecT                                   headIsHeader,
  input  logic [routerPkg::NUM_PORTS-1:0][routerPkg::LEN_WIDTH-1:0] headLength,
  output routerPkg::portVecT                                   grant
);
  import routerPkg::*;

  // one-hot states, bit 0 idle, bit k+1 held by input k
  localparam logic [5:0] ST_IDLE = 6'b000001;
  localparam logic [5:0] ST_L = 6'b000010;
  localparam logic [5:0] ST_N = 6'b000100;
  localparam logic [5:0] ST_E = 6'b001000;
  localparam logic [5:0] ST_W = 6'b010000;
  localparam logic [5:0] ST_S = 6'b100000;

  logic [5:0] state;
  logic [5:0] nextState;
  portVecT    run;
  portVecT    loadHead;
  portVecT    timesUp;

  // first requester in L,N,E,W,S order starting at start, wrapping
  function automatic logic [5:0] rotatePick(portVecT r, int unsigned start);
    int unsigned idx;
    rotatePick = ST_IDLE;
    for (int i = NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = (start + i) % NUM_PORTS;
      if (r[idx])
        rotatePick = ST_L << idx;
    end
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      ST_IDLE:
        nextState = rotatePick(reqIn, PORT_L);
      ST_L:
        if (reqIn[PORT_L] && !timesUp[PORT_L])
          nextState = ST_L;
        else
          nextState = rotatePick(reqIn, PORT_N);
      ST_N:
        if (reqIn[PORT_N] && !timesUp[PORT_N])
          nextState = ST_N;
        else
          nextState = rotatePick(reqIn, PORT_E);
      ST_E:
        if (reqIn[PORT_E] && !timesUp[PORT_E])
          nextState = ST_E;
        else
          nextState = rotatePick(reqIn, PORT_W);
      ST_W:
        if (reqIn[PORT_W] && !timesUp[PORT_W])
          nextState = ST_W;
        else
          nextState = rotatePick(reqIn, PORT_S);
      ST_S:
        if (reqIn[PORT_S] && !timesUp[PORT_S])
          nextState = ST_S;
        else
          nextState = rotatePick(reqIn, PORT_L);
      default:
        nextState = ST_IDLE;
    endcase
  end

  assign grant = state[NUM_PORTS:1];

  // flit actually leaving through this output
  assign run = grant & reqIn & popIn;
  assign loadHead = run & headIsHeader;

  for (genvar k = 0; k < NUM_PORTS; k++)
  begin : timerGen
    grantTimer timer0 (
      .clk      (clk),
      .rst      (rst),
      .run      (run[k]),
      .loadHead (loadHead[k]),
      .length   (headLength[k]),
      .timesUp  (timesUp[k])
    );
  end

endmodule

// ==== arbiter/grantTimer.sv ====
`timescale 1ns/1ps

module grantTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           run,
  input  logic                           loadHead,
  input  logic [routerPkg::LEN_WIDTH-1:0] length,
  output logic                           timesUp
);
  import routerPkg::*;

  logic [LEN_WIDTH-1:0] limit;
  logic [LEN_WIDTH-1:0] count;
  logic [LEN_WIDTH-1:0] limitNext;
  logic [LEN_WIDTH-1:0] countNext;

  always_comb
  begin
    limitNext = loadHead ? length : limit;
    if (loadHead)
      countNext = LEN_WIDTH'(1);   // header counts as first flit
    else if (run)
      countNext = count + 1'b1;
    else
      countNext = count;
  end

  // includes the flit being popped this cycle, so the arbiter
  // lets go in the same cycle the tail leaves
  assign timesUp = countNext == limitNext;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      limit <= limitNext;
      count <= countNext;
    end
  end

endmodule

// ==== inputPort/inputPort.sv ====
`timescale 1ns/1ps

module inputPort #(
  parameter int ROUTER_X = 1,
  parameter int ROUTER_Y = 1,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inValid,
  input  routerPkg::flitT     inFlit,
  input  logic                pop,
  output routerPkg::portVecT  req,
  output routerPkg::flitT     headFlit
);
  import routerPkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [COORD_WIDTH-1:0] MY_X = COORD_WIDTH'(ROUTER_X);
  localparam logic [COORD_WIDTH-1:0] MY_Y = COORD_WIDTH'(ROUTER_Y);

  flitT mem [FIFO_DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W:0]   count;

  logic    headValid;
  logic    headIsHeader;
  portVecT xyRoute;
  portVecT routeHold;   // route of the packet in flight

  assign headValid = count != '0;
  assign headFlit = mem[rdPtr];
  assign headIsHeader = headFlit.flitId == FLIT_HEAD;

  always_ff @(posedge clk)
  begin
    if (inValid)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (inValid)
        wrPtr <= (wrPtr == LAST_SLOT) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == LAST_SLOT) ? '0 : rdPtr + 1'b1;
      case ({inValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // XY order: resolve X first, then Y
  always_comb
  begin
    xyRoute = '0;
    if (headDestX(headFlit) > MY_X)
      xyRoute[PORT_E] = 1'b1;
    else if (headDestX(headFlit) < MY_X)
      xyRoute[PORT_W] = 1'b1;
    else if (headDestY(headFlit) < MY_Y)
      xyRoute[PORT_N] = 1'b1;
    else if (headDestY(headFlit) > MY_Y)
      xyRoute[PORT_S] = 1'b1;
    else
      xyRoute[PORT_L] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      routeHold <= '0;
    else if (pop && headIsHeader)
      routeHold <= xyRoute;   // kept until the next header
  end

  always_comb
  begin
    if (!headValid)
      req = '0;
    else if (headIsHeader)
      req = xyRoute;
    else
      req = routeHold;
  end

endmodule

// ==== common/routerPkg.sv ====
package routerPkg;

  localparam int NUM_PORTS = 5;
  localparam int COORD_WIDTH = 2;
  localparam int LEN_WIDTH = 12;
  localparam int DATA_WIDTH = 16;

  // port indices, also bit positions in every port vector
  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  localparam logic [2:0] FLIT_HEAD = 3'b001;
  localparam logic [2:0] FLIT_BODY = 3'b010;
  localparam logic [2:0] FLIT_TAIL = 3'b100;

  typedef struct packed {
    logic [2:0]            flitId;
    logic [DATA_WIDTH-1:0] data;
  } flitT;

  typedef logic [NUM_PORTS-1:0] portVecT;

  // header data holds destX, destY, then length in the low bits
  localparam int DEST_X_LSB = LEN_WIDTH + COORD_WIDTH;
  localparam int DEST_Y_LSB = LEN_WIDTH;
  localparam int LEN_LSB = 0;

  function automatic logic [COORD_WIDTH-1:0] headDestX(flitT f);
    return f.data[DEST_X_LSB +: COORD_WIDTH];
  endfunction

  function automatic logic [COORD_WIDTH-1:0] headDestY(flitT f);
    return f.data[DEST_Y_LSB +: COORD_WIDTH];
  endfunction

  // total flits, header and tail included
  function automatic logic [LEN_WIDTH-1:0] headLength(flitT f);
    return f.data[LEN_LSB +: LEN_WIDTH];
  endfunction

endpackage
